/* list.f */
+incdir+.
eth_frame_pkg.sv
tx_pipe_pkg.sv
stream_if.sv
crc32_d8.sv
frame_sequencer.sv
frame_byte_gen.sv
mii_nibble_tx.sv
udp_mii_tx.sv
tb_udp_mii_tx_assert.sv
tb_frame_checker.sv
tb_udp_mii_tx.sv

/* Bender.yml */
package:
  name: udp_mii_tx

sources:
  - include_dirs:
      - .
    files:
      - eth_frame_pkg.sv
      - tx_pipe_pkg.sv
      - stream_if.sv
      - crc32_d8.sv
      - frame_sequencer.sv
      - frame_byte_gen.sv
      - mii_nibble_tx.sv
      - udp_mii_tx.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_udp_mii_tx_assert.sv
      - tb_frame_checker.sv
      - tb_udp_mii_tx.sv

/* tb_udp_mii_tx.sv */
// testbench top; runs a fixed row table at the default PKT_LEN with pay_valid held high
`timescale 1ns/100ps
`include "udp_tx_defs.svh"

module tb_udp_mii_tx
	import eth_frame_pkg::*;
;

	localparam int NUM_ROWS   = 4;
	localparam int LIMIT      = NUM_ROWS * 3100 + 200;

	typedef struct packed {
		logic [127:0] name;
		hdr_fields_t  hdr;
		logic         wait_done;
	} row_t;

	logic         clk = 1'b0;
	logic         c_done;
	logic         hdr_valid;
	logic         hdr_ready;
	hdr_fields_t  hdr;
	logic [127:0] cur_name;
	logic         pay_valid;
	logic         pay_ready;
	logic [7:0]   pay_data;
	logic         mii_txen;
	logic [3:0]   mii_txd;
	logic         tx_done;
	int           frames_done;
	int           pass_count;
	int           fail_count;
	int           fails_before;
	int           own_passes;
	int           exp_frames;
	int           total_fails;
	int           cycles;
	integer       seed;
	row_t         rows [NUM_ROWS];

	always #4 clk = ~clk;

	udp_mii_tx UUT (
		.clk       (clk),
		.c_done    (c_done),
		.hdr_valid (hdr_valid),
		.hdr_ready (hdr_ready),
		.dst_mac   (hdr.dst_mac),
		.src_mac   (hdr.src_mac),
		.dst_ip    (hdr.dst_ip),
		.src_ip    (hdr.src_ip),
		.dst_port  (hdr.dst_port),
		.src_port  (hdr.src_port),
		.pay_valid (pay_valid),
		.pay_ready (pay_ready),
		.pay_data  (pay_data),
		.mii_txen  (mii_txen),
		.mii_txd   (mii_txd),
		.tx_done   (tx_done)
	);

	tb_frame_checker u_chk (
		.clk         (clk),
		.c_done      (c_done),
		.hdr_valid   (hdr_valid),
		.hdr_ready   (hdr_ready),
		.hdr         (hdr),
		.name        (cur_name),
		.pay_valid   (pay_valid),
		.pay_ready   (pay_ready),
		.pay_data    (pay_data),
		.mii_txen    (mii_txen),
		.mii_txd     (mii_txd),
		.tx_done     (tx_done),
		.frames_done (frames_done),
		.pass_count  (pass_count),
		.fail_count  (fail_count)
	);

	// new payload byte after each accepted one
	always @(posedge clk) begin
		if (pay_valid && pay_ready)
			pay_data <= 8'($random(seed));
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic send_header(input row_t r);
		@(posedge clk);
		hdr_valid <= 1'b1;
		hdr       <= r.hdr;
		cur_name  <= r.name;
		@(negedge clk);
		while (!hdr_ready)
			@(negedge clk);
		@(posedge clk);
		hdr_valid <= 1'b0;
	endtask

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////
	initial begin
		rows[0] = '{"zero_dst", '{48'h0, 48'h02_11_22_33_44_55, 32'hc0a8_0001,
			32'hc0a8_0002, 16'd1000, 16'd2000}, 1'b1};
		rows[1] = '{"single", '{48'h00_1b_21_aa_bb_cc, 48'h02_11_22_33_44_55,
			32'hc0a8_010a, 32'hc0a8_0102, 16'd5001, 16'd4000}, 1'b1};
		rows[2] = '{"b2b_first", '{48'hff_ff_ff_ff_ff_ff, 48'h02_de_ad_00_00_01,
			32'h0a00_00ff, 32'h0a00_0001, 16'hffff, 16'h0001}, 1'b0};
		rows[3] = '{"b2b_second", '{48'h00_00_00_00_00_01, 48'h02_de_ad_00_00_02,
			32'hefff_fffa, 32'hac10_8001, 16'd53, 16'd60000}, 1'b1};

		seed       = 47456;
		cycles     = 0;
		own_passes = 0;
		exp_frames = 0;
		c_done     = 1'b0;
		hdr_valid  = 1'b0;
		hdr        = '0;
		cur_name   = '0;
		pay_valid  = 1'b0;
		pay_data   = 8'($random(seed));
		repeat (10) @(posedge clk);
		c_done <= 1'b1;
		@(posedge clk);
		pay_valid <= 1'b1;

		for (int i = 0; i < NUM_ROWS; i++) begin
			send_header(rows[i]);
			if (rows[i].hdr.dst_mac == '0) begin
				// the checker flags any MII activity for a dropped header
				fails_before = fail_count;
				repeat (40) @(negedge clk);
				if (fail_count == fails_before) begin
					$display("PASS %0s", rows[i].name);
					own_passes++;
				end else begin
					$display("FAIL %0s", rows[i].name);
				end
			end else begin
				exp_frames++;
				if (rows[i].wait_done) begin
					while (frames_done < exp_frames)
						@(negedge clk);
				end
			end
		end
		while (frames_done < exp_frames)
			@(negedge clk);

		total_fails = fail_count + UUT.u_seq.u_seq_rules.assert_fails
			+ UUT.u_mii.u_mii_rules.assert_fails;
		$display("%0d tests run, %0d passed, %0d failed", NUM_ROWS,
			pass_count + own_passes, total_fails);
		if (total_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* tb_frame_checker.sv */
// rebuilds frames from MII nibbles and compares them; expects whole frames with pay_valid held high
`timescale 1ns/100ps
`include "udp_tx_defs.svh"

module tb_frame_checker
	import eth_frame_pkg::*;
(
	input  logic         clk,
	input  logic         c_done,
	input  logic         hdr_valid,
	input  logic         hdr_ready,
	input  hdr_fields_t  hdr,
	input  logic [127:0] name,
	input  logic         pay_valid,
	input  logic         pay_ready,
	input  logic [7:0]   pay_data,
	input  logic         mii_txen,
	input  logic [3:0]   mii_txd,
	input  logic         tx_done,
	output int           frames_done,
	output int           pass_count,
	output int           fail_count
);

	hdr_fields_t  hdr_q[$];
	logic [127:0] name_q[$];
	logic [7:0]   pay_q[$];
	logic [7:0]   rx[$];
	logic [3:0]   lo_nib;
	logic         have_lo;

	// Ethernet CRC-32, reflected, one data bit per step
	function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		logic        fb;
		r = c;
		for (int b = 0; b < 8; b++) begin
			fb = r[0] ^ d[b];
			r = r >> 1;
			if (fb)
				r = r ^ 32'hedb88320;
		end
		return r;
	endfunction

	function automatic void push16(ref logic [7:0] q[$], input logic [15:0] v);
		q.push_back(v[15:8]);
		q.push_back(v[7:0]);
	endfunction

	////////////////////////////////////////
	// expected frame and comparison
	////////////////////////////////////////
	task automatic check_frame();
		logic [7:0]   exp_b[$];
		hdr_fields_t  h;
		logic [127:0] nm;
		logic [31:0]  c;
		logic [31:0]  sum;
		int           bad;
		bad = 0;
		if (hdr_q.size() == 0) begin
			$display("tx_done seen with no header pending");
			fail_count++;
			return;
		end
		h = hdr_q.pop_front();
		nm = name_q.pop_front();
		for (int i = 0; i < 7; i++)
			exp_b.push_back(8'h55);
		exp_b.push_back(8'hd5);
		for (int i = 0; i < 6; i++)
			exp_b.push_back(h.dst_mac[47 - 8 * i -: 8]);
		for (int i = 0; i < 6; i++)
			exp_b.push_back(h.src_mac[47 - 8 * i -: 8]);
		push16(exp_b, 16'h0800);
		// ip header, checksum patched below at bytes 32..33
		push16(exp_b, 16'h4500);
		push16(exp_b, 16'(`PKT_LEN + 28));
		push16(exp_b, 16'h0000);
		push16(exp_b, 16'h0000);
		push16(exp_b, 16'h4011);
		push16(exp_b, 16'h0000);
		push16(exp_b, h.src_ip[31:16]);
		push16(exp_b, h.src_ip[15:0]);
		push16(exp_b, h.dst_ip[31:16]);
		push16(exp_b, h.dst_ip[15:0]);
		sum = 0;
		for (int i = 22; i < 42; i += 2)
			sum = sum + {exp_b[i], exp_b[i + 1]};
		while (sum[31:16] != 0)
			sum = sum[15:0] + sum[31:16];
		exp_b[32] = ~sum[15:8];
		exp_b[33] = ~sum[7:0];
		push16(exp_b, h.src_port);
		push16(exp_b, h.dst_port);
		push16(exp_b, 16'(`PKT_LEN + 8));
		push16(exp_b, 16'h0000);
		if (pay_q.size() < `PKT_LEN) begin
			$display("%0s: fewer payload bytes accepted than one frame needs", nm);
			bad++;
		end
		for (int i = 0; i < `PKT_LEN && pay_q.size() > 0; i++)
			exp_b.push_back(pay_q.pop_front());
		c = '1;
		for (int i = 8; i < exp_b.size(); i++)
			c = crc_update(c, exp_b[i]);
		c = ~c;
		for (int i = 0; i < 4; i++)
			exp_b.push_back(c[8 * i +: 8]);
		if (rx.size() != exp_b.size()) begin
			$display("ERR %0s frame length: expected %0d, actual %0d", nm, exp_b.size(), rx.size());
			bad++;
		end else begin
			for (int i = 0; i < rx.size() && bad == 0; i++) begin
				if (rx[i] !== exp_b[i]) begin
					$display("ERR %0s byte %0d: expected %h, actual %h", nm, i, exp_b[i], rx[i]);
					bad++;
				end
			end
		end
		if (bad == 0) begin
			$display("PASS %0s", nm);
			pass_count++;
		end else begin
			$display("FAIL %0s", nm);
			fail_count++;
		end
	endtask

	// outputs are registered, so values read at the edge are the settled ones
	always @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			have_lo = 1'b0;
			frames_done = 0;
			pass_count = 0;
			fail_count = 0;
		end else begin
			if (hdr_valid && hdr_ready && hdr.dst_mac != '0) begin
				hdr_q.push_back(hdr);
				name_q.push_back(name);
			end
			if (pay_valid && pay_ready)
				pay_q.push_back(pay_data);
			// close the old frame before a new one's first nibble
			if (tx_done) begin
				check_frame();
				frames_done++;
				rx.delete();
				have_lo = 1'b0;
			end
			if (mii_txen) begin
				if (rx.size() == 0 && !have_lo && hdr_q.size() == 0) begin
					$display("mii_txen active with no accepted header");
					fail_count++;
				end
				if (!have_lo) begin
					lo_nib = mii_txd;
					have_lo = 1'b1;
				end else begin
					rx.push_back({mii_txd, lo_nib});
					have_lo = 1'b0;
				end
			end
		end
	end

endmodule

/* tb_udp_mii_tx_assert.sv */
// handshake and MII rules; bound to frame_sequencer and mii_nibble_tx, item widened to 16 bits
`timescale 1ns/100ps

module tb_udp_mii_tx_assert (
	input logic        clk,
	input logic        c_done,
	input logic        valid,
	input logic        ready,
	input logic [15:0] item,
	input logic        last,
	input logic        hold_low,
	input logic        start,
	input logic        start_ok
);

	int   assert_fails = 0;
	logic in_flight;

	// open from start_ok until the item marked last is taken
	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			in_flight <= 1'b0;
		end else if (valid && ready && last) begin
			in_flight <= 1'b0;
		end else if (start_ok) begin
			in_flight <= 1'b1;
		end
	end

	// source keeps item and last while stalled
	stall_stable: assert property (@(posedge clk) disable iff (!c_done)
		valid && !ready |=> valid && $stable(item) && $stable(last))
		else begin
			$error("stream item changed under a stall");
			assert_fails++;
		end

	busy_hold_low: assert property (@(posedge clk) disable iff (!c_done)
		in_flight |-> !hold_low)
		else begin
			$error("signal that must stay low went high while a frame is in flight");
			assert_fails++;
		end

	start_cause: assert property (@(posedge clk) disable iff (!c_done)
		$rose(start) |-> $past(start_ok))
		else begin
			$error("activity started without a preceding transfer");
			assert_fails++;
		end

endmodule

// sequencer output must follow an accepted header with a nonzero destination
bind frame_sequencer tb_udp_mii_tx_assert u_seq_rules (
	.clk      (clk),
	.c_done   (c_done),
	.valid    (seq_s.valid),
	.ready    (seq_s.ready),
	.item     ({2'b00, seq_s.item}),
	.last     (seq_s.last),
	.hold_low (hdr_ready),
	.start    (seq_s.valid),
	.start_ok (hdr_valid && hdr_ready && (hdr.dst_mac != '0))
);

// mii_txen starts on a preamble byte and stays high up to the last FCS byte
bind mii_nibble_tx tb_udp_mii_tx_assert u_mii_rules (
	.clk      (clk),
	.c_done   (c_done),
	.valid    (byte_s.valid),
	.ready    (byte_s.ready),
	.item     ({8'h00, byte_s.item}),
	.last     (byte_s.last),
	.hold_low (!mii_txen),
	.start    (mii_txen),
	.start_ok (byte_s.valid && byte_s.ready && (byte_s.item == 8'h55))
);

/* udp_mii_tx.sv */
// UDP/IPv4 frame transmitter on 4-bit MII; payload length fixed, pay_valid must keep up
`timescale 1ns/100ps

module udp_mii_tx
	import eth_frame_pkg::*, tx_pipe_pkg::*;
(
	input  logic        clk,
	input  logic        c_done,
	// header handshake
	input  logic        hdr_valid,
	output logic        hdr_ready,
	input  logic [47:0] dst_mac,
	input  logic [47:0] src_mac,
	input  logic [31:0] dst_ip,
	input  logic [31:0] src_ip,
	input  logic [15:0] dst_port,
	input  logic [15:0] src_port,
	// payload byte stream
	input  logic        pay_valid,
	output logic        pay_ready,
	input  logic [7:0]  pay_data,
	// MII side
	output logic        mii_txen,
	output logic [3:0]  mii_txd,
	output logic        tx_done
);

	hdr_fields_t hdr;
	hdr_fields_t fields;
	logic [15:0] ip_csum;
	logic [15:0] ip_total_len;
	logic [15:0] udp_len;

	stream_if #(.T(seq_item_t))  seq_s ();
	stream_if #(.T(byte_item_t)) byte_s ();

	assign hdr = '{dst_mac: dst_mac, src_mac: src_mac, dst_ip: dst_ip,
		src_ip: src_ip, dst_port: dst_port, src_port: src_port};

	////////////////////////////////////////
	// decode -> execute -> result
	////////////////////////////////////////
	frame_sequencer u_seq (
		.clk          (clk),
		.c_done       (c_done),
		.hdr_valid    (hdr_valid),
		.hdr          (hdr),
		.hdr_ready    (hdr_ready),
		.fields       (fields),
		.ip_csum      (ip_csum),
		.ip_total_len (ip_total_len),
		.udp_len      (udp_len),
		.seq_s        (seq_s.src)
	);

	frame_byte_gen u_gen (
		.clk          (clk),
		.c_done       (c_done),
		.fields       (fields),
		.ip_csum      (ip_csum),
		.ip_total_len (ip_total_len),
		.udp_len      (udp_len),
		.pay_valid    (pay_valid),
		.pay_data     (pay_data),
		.pay_ready    (pay_ready),
		.seq_s        (seq_s.snk),
		.byte_s       (byte_s.src)
	);

	mii_nibble_tx u_mii (
		.clk      (clk),
		.c_done   (c_done),
		.byte_s   (byte_s.snk),
		.mii_txen (mii_txen),
		.mii_txd  (mii_txd),
		.tx_done  (tx_done)
	);

endmodule

/* mii_nibble_tx.sv */
// MII nibble serializer, low nibble first; a late byte drops mii_txen between bytes
`timescale 1ns/100ps

module mii_nibble_tx (
	input  logic       clk,
	input  logic       c_done,
	stream_if.snk      byte_s,
	output logic       mii_txen,
	output logic [3:0] mii_txd,
	output logic       tx_done
);

	logic       phase_hi;
	logic [3:0] hi_nib;
	logic       byte_last;
	logic       byte_xfer;

	// take a byte when idle or while the high nibble is on the wire
	assign byte_s.ready = !mii_txen || phase_hi;
	assign byte_xfer    = byte_s.valid && byte_s.ready;

	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			mii_txen <= 1'b0;
			mii_txd  <= 4'h0;
			phase_hi <= 1'b0;
			tx_done  <= 1'b0;
		end else begin
			tx_done <= mii_txen && phase_hi && byte_last;
			if (byte_xfer) begin
				mii_txen <= 1'b1;
				mii_txd  <= byte_s.item[3:0];
				phase_hi <= 1'b0;
			end else if (mii_txen && !phase_hi) begin
				mii_txd  <= hi_nib;
				phase_hi <= 1'b1;
			end else begin
				// nothing waiting after the high nibble
				mii_txen <= 1'b0;
				phase_hi <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_xfer) begin
			hi_nib    <= byte_s.item[7:4];
			byte_last <= byte_s.last;
		end
	end

endmodule

/* frame_byte_gen.sv */
// byte mapping per section; payload bytes must arrive on pay_data or the frame stalls
`timescale 1ns/100ps
`include "udp_tx_defs.svh"

module frame_byte_gen
	import eth_frame_pkg::*, tx_pipe_pkg::*;
(
	input  logic         clk,
	input  logic         c_done,
	input  hdr_fields_t  fields,
	input  logic [15:0]  ip_csum,
	input  logic [15:0]  ip_total_len,
	input  logic [15:0]  udp_len,
	input  logic         pay_valid,
	input  logic [7:0]   pay_data,
	output logic         pay_ready,
	stream_if.snk        seq_s,
	stream_if.src        byte_s
);

	logic         can_accept;
	logic         pay_item;
	logic         seq_xfer;
	logic         crc_init;
	logic         crc_en;
	logic [31:0]  crc;
	logic [31:0]  fcs;
	logic [111:0] eth_hdr;
	logic [159:0] ip_hdr;
	logic [63:0]  udp_hdr;
	byte_item_t   next_byte;

	// output register empty or draining this cycle
	assign can_accept = !byte_s.valid || byte_s.ready;
	assign pay_item   = seq_s.valid && (seq_s.item.sect == PAYLOAD);
	assign seq_s.ready = can_accept && (!pay_item || pay_valid);
	assign pay_ready  = can_accept && pay_item && pay_valid;
	assign seq_xfer   = seq_s.valid && seq_s.ready;

	////////////////////////////////////////
	// header images, msb byte sent first
	////////////////////////////////////////
	assign eth_hdr = {fields.dst_mac, fields.src_mac, `ETH_TYPE_IPV4};
	assign ip_hdr  = {`IP_VER, `IP_IHL, `IP_TOS, ip_total_len, `IP_ID,
		`IP_FLAGS, `IP_FRAG_OFF, `IP_TTL, `IP_PROTO_UDP, ip_csum,
		fields.src_ip, fields.dst_ip};
	assign udp_hdr = {fields.src_port, fields.dst_port, udp_len, `UDP_CSUM};
	assign fcs     = ~crc;

	always_comb begin
		case (seq_s.item.sect)
			PREAMBLE: begin
				next_byte = (seq_s.item.idx == 11'(`PREAMBLE_LEN - 1)) ? `SFD_BYTE
					: `PREAMBLE_BYTE;
			end
			ETH_HDR: next_byte = eth_hdr[8 * (`ETH_HDR_LEN - 1 - int'(seq_s.item.idx)) +: 8];
			IP_HDR:  next_byte = ip_hdr[8 * (`IP_HDR_LEN - 1 - int'(seq_s.item.idx)) +: 8];
			UDP_HDR: next_byte = udp_hdr[8 * (`UDP_HDR_LEN - 1 - int'(seq_s.item.idx)) +: 8];
			PAYLOAD: next_byte = pay_data;
			// fcs goes out lsb byte first
			default: next_byte = fcs[8 * seq_s.item.idx[1:0] +: 8];
		endcase
	end

	// crc covers ethernet header through payload
	assign crc_init = seq_xfer && (seq_s.item.sect == PREAMBLE) && (seq_s.item.idx == '0);
	assign crc_en   = seq_xfer && (seq_s.item.sect != PREAMBLE) && (seq_s.item.sect != FCS);

	crc32_d8 u_crc (
		.clk      (clk),
		.c_done   (c_done),
		.data     (next_byte),
		.crc_init (crc_init),
		.crc_en   (crc_en),
		.crc      (crc)
	);

	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			byte_s.valid <= 1'b0;
		end else if (seq_xfer) begin
			byte_s.valid <= 1'b1;
		end else if (byte_s.ready) begin
			byte_s.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (seq_xfer) begin
			byte_s.item <= next_byte;
			byte_s.last <= seq_s.last;
		end
	end

endmodule

/* frame_sequencer.sv */
// header capture and section walk; a zero destination MAC is accepted and dropped
`timescale 1ns/100ps
`include "udp_tx_defs.svh"

module frame_sequencer
	import eth_frame_pkg::*, tx_pipe_pkg::*;
(
	input  logic         clk,
	input  logic         c_done,
	input  logic         hdr_valid,
	input  hdr_fields_t  hdr,
	output logic         hdr_ready,
	output hdr_fields_t  fields,
	output logic [15:0]  ip_csum,
	output logic [15:0]  ip_total_len,
	output logic [15:0]  udp_len,
	stream_if.src        seq_s
);

	localparam logic [15:0] UDP_LEN_C  = 16'(`PKT_LEN + `UDP_HDR_LEN);
	localparam logic [15:0] IP_TOTAL_C = 16'(`PKT_LEN + `UDP_HDR_LEN + `IP_HDR_LEN);

	typedef enum logic {
		S_IDLE,
		S_SEQ
	} state_t;

	state_t      state;
	frame_sect_t sect;
	logic [10:0] idx;
	logic        hdr_xfer;
	logic        frame_go;

	// last index of each section
	function automatic logic [10:0] sect_last(input frame_sect_t s);
		case (s)
			PREAMBLE: return 11'(`PREAMBLE_LEN - 1);
			ETH_HDR:  return 11'(`ETH_HDR_LEN - 1);
			IP_HDR:   return 11'(`IP_HDR_LEN - 1);
			UDP_HDR:  return 11'(`UDP_HDR_LEN - 1);
			PAYLOAD:  return 11'(`PKT_LEN - 1);
			default:  return 11'(`FCS_LEN - 1);
		endcase
	endfunction

	function automatic frame_sect_t sect_next(input frame_sect_t s);
		case (s)
			PREAMBLE: return ETH_HDR;
			ETH_HDR:  return IP_HDR;
			IP_HDR:   return UDP_HDR;
			UDP_HDR:  return PAYLOAD;
			PAYLOAD:  return FCS;
			default:  return PREAMBLE;
		endcase
	endfunction

	// ones' complement sum over the ten header words, checksum word taken as zero
	function automatic logic [15:0] ip_hdr_csum(input hdr_fields_t f, input logic [15:0] tot);
		logic [19:0] sum;
		sum = 20'({`IP_VER, `IP_IHL, `IP_TOS}) + 20'(tot) + 20'(`IP_ID)
			+ 20'({`IP_FLAGS, `IP_FRAG_OFF}) + 20'({`IP_TTL, `IP_PROTO_UDP})
			+ 20'(f.src_ip[31:16]) + 20'(f.src_ip[15:0])
			+ 20'(f.dst_ip[31:16]) + 20'(f.dst_ip[15:0]);
		// two folds cover any carry out of ten words
		sum = 20'(sum[15:0]) + 20'(sum[19:16]);
		sum = 20'(sum[15:0]) + 20'(sum[19:16]);
		return ~sum[15:0];
	endfunction

	assign hdr_ready = (state == S_IDLE);
	assign hdr_xfer  = hdr_valid && hdr_ready;
	assign frame_go  = hdr_xfer && (hdr.dst_mac != '0);

	assign seq_s.valid = (state == S_SEQ);
	assign seq_s.item  = seq_item_t'{sect: sect, idx: idx};
	assign seq_s.last  = (sect == FCS) && (idx == 11'(`FCS_LEN - 1));

	////////////////////////////////////////
	// section / index walk
	////////////////////////////////////////
	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			state <= S_IDLE;
			sect  <= PREAMBLE;
			idx   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (frame_go) begin
						state <= S_SEQ;
						sect  <= PREAMBLE;
						idx   <= '0;
					end
				end
				default: begin
					if (seq_s.ready) begin
						if (seq_s.last) begin
							state <= S_IDLE;
						end else if (idx == sect_last(sect)) begin
							sect <= sect_next(sect);
							idx  <= '0;
						end else begin
							idx <= idx + 11'd1;
						end
					end
				end
			endcase
		end
	end

	// header fields held for the whole frame
	always_ff @(posedge clk) begin
		if (frame_go) begin
			fields <= hdr;
		end
	end

	// ready one cycle after capture, long before the ip header is sent
	always_ff @(posedge clk) begin
		ip_total_len <= IP_TOTAL_C;
		udp_len      <= UDP_LEN_C;
		ip_csum      <= ip_hdr_csum(fields, IP_TOTAL_C);
	end

endmodule

/* crc32_d8.sv */
// reflected Ethernet CRC-32, one byte per enable; crc is the raw register, not complemented
`timescale 1ns/100ps

module crc32_d8 (
	input  logic        clk,
	input  logic        c_done,
	input  logic [7:0]  data,
	input  logic        crc_init,
	input  logic        crc_en,
	output logic [31:0] crc
);

	// 04c11db7 bit reversed
	localparam logic [31:0] POLY_REFL = 32'hedb88320;

	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'h0, d};
		// lsb first, one shift per data bit
		for (int i = 0; i < 8; i++) begin
			r = r[0] ? ((r >> 1) ^ POLY_REFL) : (r >> 1);
		end
		return r;
	endfunction

	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			crc <= '1;
		end else if (crc_init) begin
			crc <= '1;
		end else if (crc_en) begin
			crc <= crc_step(crc, data);
		end
	end

endmodule

/* stream_if.sv */
// valid/ready link; source must hold item and last while valid is high and ready low
`timescale 1ns/100ps

interface stream_if #(
	parameter type T = logic [7:0]
);
	logic valid;
	logic ready;
	T     item;
	// marks the final item of a frame
	logic last;

	modport src (
		output valid, item, last,
		input  ready
	);

	modport snk (
		input  valid, item, last,
		output ready
	);

endinterface

/* tx_pipe_pkg.sv */
// items passed between pipeline stages; byte index is limited to 11 bits
package tx_pipe_pkg;

	// section plus byte position inside that section
	typedef struct packed {
		eth_frame_pkg::frame_sect_t sect;
		logic [10:0]                idx;
	} seq_item_t;

	// one frame byte on its way to the serializer
	typedef logic [7:0] byte_item_t;

endpackage

/* eth_frame_pkg.sv */
// protocol level types; field values are big-endian as they appear on the wire
package eth_frame_pkg;

	// one frame's addressing, captured per header handshake
	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [31:0] dst_ip;
		logic [31:0] src_ip;
		logic [15:0] dst_port;
		logic [15:0] src_port;
	} hdr_fields_t;

	// frame sections in transmit order
	typedef enum logic [2:0] {
		PREAMBLE = 3'd0,
		ETH_HDR  = 3'd1,
		IP_HDR   = 3'd2,
		UDP_HDR  = 3'd3,
		PAYLOAD  = 3'd4,
		FCS      = 3'd5
	} frame_sect_t;

endpackage

/* udp_tx_defs.svh */
// frame constants for the UDP transmitter; PKT_LEN is fixed here and must stay below 2048
`ifndef UDP_TX_DEFS_SVH
`define UDP_TX_DEFS_SVH

////////////////////////////////////////
// section lengths in bytes
////////////////////////////////////////
`define PKT_LEN        1452
`define PREAMBLE_LEN   8
`define ETH_HDR_LEN    14
`define IP_HDR_LEN     20
`define UDP_HDR_LEN    8
`define FCS_LEN        4

// preamble fill and start of frame delimiter
`define PREAMBLE_BYTE  8'h55
`define SFD_BYTE       8'hd5

////////////////////////////////////////
// fixed header field values
////////////////////////////////////////
`define ETH_TYPE_IPV4  16'h0800
`define IP_VER         4'h4
`define IP_IHL         4'h5
`define IP_TOS         8'h00
`define IP_ID          16'h0000
`define IP_FLAGS       3'b000
`define IP_FRAG_OFF    13'h0000
`define IP_TTL         8'd64
`define IP_PROTO_UDP   8'd17
`define UDP_CSUM       16'h0000

`endif
